// File: logic/soc_map_pkg.sv
package soc_map_pkg;

  // ********************
  // Bus widths
  // ********************

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // One bit per byte lane
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // ********************
  // Address map
  // ********************

  // Regions come from address bits 31 to 29
  typedef enum logic [1:0] {
    REG_RAM,
    REG_LCD,
    REG_AUDIO,
    REG_NONE
  } region_t;

  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);  // Word index taken from address bits above 1:0

endpackage

// File: logic/periph_pkg.sv
package periph_pkg;

  // ********************
  // LCD
  // ********************

  typedef logic [7:0] lcd_byte_t;
  typedef logic [2:0] lcd_cnt_t;  // Phase counter, wide enough for the longest phase

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    PULSE,
    HOLD
  } lcd_state_t;

  // Phase lengths in clock cycles
  localparam lcd_cnt_t LCD_SETUP = 3'd2;
  localparam lcd_cnt_t LCD_PULSE = 3'd4;
  localparam lcd_cnt_t LCD_HOLD  = 3'd2;

  // ********************
  // Audio
  // ********************

  typedef logic [15:0] period_t;  // Half-period of the tone in clock cycles

endpackage

// File: logic/periph_bus_if.sv
interface periph_bus_if;
  import soc_map_pkg::*;

  addr_t addr;
  data_t wdata;
  strb_t wstrb;
  logic  wr;
  logic  rd;
  logic  ready;  // Low stalls the request
  data_t rdata;  // Valid the cycle after completion
  logic  err;    // Valid the cycle after completion

  modport master (
    output addr, wdata, wstrb, wr, rd,
    input  ready, rdata, err
  );

  modport slave (
    input  addr, wdata, wstrb, wr, rd,
    output ready, rdata, err
  );

endinterface

// File: logic/axil_bridge.sv
module axil_bridge (
  input  logic                clk,
  input  logic                arst_n,
  input  soc_map_pkg::addr_t  awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  soc_map_pkg::data_t  wdata,
  input  soc_map_pkg::strb_t  wstrb,
  input  logic                wvalid,
  output logic                wready,
  output soc_map_pkg::resp_t  bresp,
  output logic                bvalid,
  input  logic                bready,
  input  soc_map_pkg::addr_t  araddr,
  input  logic                arvalid,
  output logic                arready,
  output soc_map_pkg::data_t  rdata,
  output soc_map_pkg::resp_t  rresp,
  output logic                rvalid,
  input  logic                rready,
  periph_bus_if.master        bus
);
  import soc_map_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_AR,    // arready high
    S_AW,    // awready and wready high
    S_REQ,   // Access on the peripheral bus
    S_RESP   // bvalid or rvalid high
  } state_t;

  state_t state;
  logic   is_read;
  logic   first;    // First response cycle, bus result is live
  addr_t  addr_q;
  data_t  wdata_q;
  strb_t  wstrb_q;
  data_t  rdata_q;
  resp_t  resp_q;
  resp_t  resp_now;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= S_IDLE;
      is_read <= 1'b0;
      first   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (arvalid) begin  // Reads win ties
            state   <= S_AR;
            is_read <= 1'b1;
          end else if (awvalid && wvalid) begin
            state   <= S_AW;
            is_read <= 1'b0;
          end
        end
        S_AR, S_AW: state <= S_REQ;
        S_REQ: begin
          if (bus.ready) begin
            state <= S_RESP;
            first <= 1'b1;
          end
        end
        default: begin
          first <= 1'b0;
          if (is_read ? rready : bready) state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_AR) addr_q <= araddr;
    if (state == S_AW) begin
      addr_q  <= awaddr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (state == S_RESP && first) begin  // Keep the result while the master stalls
      rdata_q <= bus.rdata;
      resp_q  <= resp_now;
    end
  end

  assign resp_now = bus.err ? RESP_SLVERR : RESP_OKAY;

  assign arready = (state == S_AR);
  assign awready = (state == S_AW);
  assign wready  = (state == S_AW);

  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.wstrb = wstrb_q;
  assign bus.wr    = (state == S_REQ) && !is_read;
  assign bus.rd    = (state == S_REQ) && is_read;

  assign bvalid = (state == S_RESP) && !is_read;
  assign rvalid = (state == S_RESP) && is_read;
  assign rdata  = first ? bus.rdata : rdata_q;
  assign rresp  = first ? resp_now : resp_q;
  assign bresp  = first ? resp_now : resp_q;

endmodule

// File: logic/word_ram.sv
module word_ram (
  input  logic                                 clk,
  input  logic                                 wr,
  input  logic                                 rd,
  input  logic [soc_map_pkg::RAM_AW-1:0]       index,
  input  soc_map_pkg::data_t                   wdata,
  input  soc_map_pkg::strb_t                   wstrb,
  output soc_map_pkg::data_t                   rdata
);
  import soc_map_pkg::*;

  data_t mem [RAM_WORDS];
  data_t merged;  // Stored word with the strobed bytes replaced

  always_comb begin
    merged = mem[index];
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (wr) mem[index] <= merged;
    if (rd) begin
      // Write-first when both hit the same word
      rdata <= wr ? merged : mem[index];
    end
  end

endmodule

// File: logic/lcd_unit.sv
module lcd_unit (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    wr,
  input  logic                    rs,
  input  periph_pkg::lcd_byte_t   wdata,
  output logic                    busy,
  output soc_map_pkg::data_t      status,
  output periph_pkg::lcd_byte_t   lcd_data,
  output logic                    lcd_rs,
  output logic                    lcd_enable
);
  import periph_pkg::*;

  lcd_state_t state;
  lcd_cnt_t   cnt;
  logic       phase_done;
  logic       accept;

  assign phase_done = (cnt == '0);
  assign accept     = wr && (state == IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      if (state != IDLE) cnt <= cnt - 3'd1;
      case (state)
        IDLE: begin
          if (accept) begin
            state <= SETUP;
            cnt   <= LCD_SETUP - 3'd1;
          end
        end
        SETUP: begin
          if (phase_done) begin
            state <= PULSE;
            cnt   <= LCD_PULSE - 3'd1;
          end
        end
        PULSE: begin
          if (phase_done) begin
            state <= HOLD;
            cnt   <= LCD_HOLD - 3'd1;
          end
        end
        default: begin
          if (phase_done) state <= IDLE;
        end
      endcase
    end
  end

  // Byte and rs stay put until the next accepted write
  always_ff @(posedge clk) begin
    if (accept) begin
      lcd_data <= wdata;
      lcd_rs   <= rs;
    end
  end

  assign busy       = (state != IDLE);
  assign lcd_enable = (state == PULSE);
  assign status     = {23'd0, busy, lcd_data};

endmodule

// File: logic/audio_unit.sv
module audio_unit (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr,
  input  soc_map_pkg::data_t   wdata,
  input  soc_map_pkg::strb_t   wstrb,
  output periph_pkg::period_t  period,
  output logic                 audio_out
);
  import periph_pkg::*;

  period_t cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      period    <= '0;
      cnt       <= '0;
      audio_out <= 1'b0;
    end else if (wr && (&wstrb)) begin  // Only a full word loads the period
      period    <= wdata[15:0];
      cnt       <= '0;
      audio_out <= 1'b0;
    end else if (period == '0) begin
      cnt       <= '0;
      audio_out <= 1'b0;  // Silent
    end else if (cnt >= period - 16'd1) begin
      cnt       <= '0;
      audio_out <= ~audio_out;
    end else begin
      cnt <= cnt + 16'd1;
    end
  end

endmodule

// File: logic/periph_top.sv
module periph_top (
  input  logic                clk,
  input  logic                arst_n,
  input  soc_map_pkg::addr_t  awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  soc_map_pkg::data_t  wdata,
  input  soc_map_pkg::strb_t  wstrb,
  input  logic                wvalid,
  output logic                wready,
  output soc_map_pkg::resp_t  bresp,
  output logic                bvalid,
  input  logic                bready,
  input  soc_map_pkg::addr_t  araddr,
  input  logic                arvalid,
  output logic                arready,
  output soc_map_pkg::data_t  rdata,
  output soc_map_pkg::resp_t  rresp,
  output logic                rvalid,
  input  logic                rready,
  output periph_pkg::lcd_byte_t lcd_data,
  output logic                lcd_rs,
  output logic                lcd_enable,
  output logic                audio_out
);
  import soc_map_pkg::*;
  import periph_pkg::*;

  periph_bus_if bus ();

  region_t region;
  region_t rd_region_q;   // Region of the last completed read
  logic    acc_wr;
  logic    acc_rd;
  data_t   ram_rdata;
  data_t   lcd_status;
  logic    lcd_busy;
  period_t audio_period;

  axil_bridge bridge (
    .clk     (clk),
    .arst_n  (arst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .bus     (bus.master)
  );

  // ********************
  // Region decode
  // ********************

  always_comb begin
    casez (bus.addr[31:29])
      3'b00?:  region = REG_RAM;
      3'b110:  region = REG_LCD;
      3'b111:  region = REG_AUDIO;
      default: region = REG_NONE;
    endcase
  end

  // Only the LCD can stall, and only while a sequence runs
  assign bus.ready = !(region == REG_LCD && lcd_busy);
  assign acc_wr    = bus.wr && bus.ready;
  assign acc_rd    = bus.rd && bus.ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus.err     <= 1'b0;
      rd_region_q <= REG_NONE;
    end else begin
      bus.err <= (region == REG_NONE);
      if (acc_rd) rd_region_q <= region;
    end
  end

  always_comb begin
    case (rd_region_q)
      REG_RAM:   bus.rdata = ram_rdata;
      REG_LCD:   bus.rdata = lcd_status;
      REG_AUDIO: bus.rdata = {16'd0, audio_period};
      default:   bus.rdata = '0;  // Unmapped reads return zero
    endcase
  end

  // ********************
  // Blocks
  // ********************

  word_ram ram (
    .clk   (clk),
    .wr    (acc_wr && region == REG_RAM),
    .rd    (acc_rd && region == REG_RAM),
    .index (bus.addr[RAM_AW+1:2]),
    .wdata (bus.wdata),
    .wstrb (bus.wstrb),
    .rdata (ram_rdata)
  );

  lcd_unit lcd (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr         (acc_wr && region == REG_LCD),
    .rs         (bus.addr[2]),
    .wdata      (bus.wdata[7:0]),
    .busy       (lcd_busy),
    .status     (lcd_status),
    .lcd_data   (lcd_data),
    .lcd_rs     (lcd_rs),
    .lcd_enable (lcd_enable)
  );

  audio_unit audio (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr        (acc_wr && region == REG_AUDIO),
    .wdata     (bus.wdata),
    .wstrb     (bus.wstrb),
    .period    (audio_period),
    .audio_out (audio_out)
  );

endmodule

// File: sim/periph_sva.sv
module periph_sva (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  bvalid,
  input logic                  bready,
  input logic                  rvalid,
  input logic                  rready,
  input logic                  wr,
  input logic                  rd,
  input logic                  ready,
  input soc_map_pkg::addr_t    addr,
  input logic                  lcd_enable,
  input periph_pkg::lcd_byte_t lcd_data
);

  // ********************
  // Bridge handshake
  // ********************

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // A stalled request keeps its kind and address
  a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (wr || rd) && !ready |=> $stable({wr, rd, addr}))
    else $error("request changed while ready was low");

  // ********************
  // LCD outputs
  // ********************

  // Data must be settled through the rising edge and the whole pulse
  a_lcd_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
    lcd_enable |-> $stable(lcd_data))
    else $error("lcd_data changed while lcd_enable was high");

endmodule

// File: sim/periph_tb.sv
module periph_tb;
  import soc_map_pkg::*;
  import periph_pkg::*;

  localparam int TIMEOUT = 300;  // Cycles allowed for any single wait

  logic      clk, arst_n;
  logic      awvalid, awready, wvalid, wready, bvalid, bready;
  logic      arvalid, arready, rvalid, rready;
  addr_t     awaddr, araddr;
  data_t     wdata, rdata;
  strb_t     wstrb;
  resp_t     bresp, rresp;
  lcd_byte_t lcd_data;
  logic      lcd_rs, lcd_enable, audio_out;

  int          data_errs, resp_errs, lcd_errs, other_errs;
  int unsigned cycle = 0;
  data_t       ram_model [RAM_WORDS];
  lcd_byte_t   lcd_last;
  period_t     period_model;
  logic [8:0]  lcd_exp_q [$];  // {rs, byte} of each LCD write
  logic [8:0]  pulse_q [$];    // {rs, byte} seen on each enable pulse
  int unsigned toggle_q [$];   // Cycle of each audio_out edge
  int          pulse_len = 0;
  int          fall_cycle = 0;    // Cycle in which lcd_enable last fell
  int          bvalid_cycle = 0;  // Cycle in which the last bvalid was seen
  logic        enable_prev = 1'b0;
  logic        audio_prev = 1'b0;

  periph_top uut (.*);

  bind axil_bridge periph_sva bridge_checks (
    .clk        (clk),
    .arst_n     (arst_n),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .wr         (bus.wr),
    .rd         (bus.rd),
    .ready      (bus.ready),
    .addr       (bus.addr),
    .lcd_enable (1'b0),
    .lcd_data   (8'h00)
  );

  bind lcd_unit periph_sva lcd_checks (
    .clk        (clk),
    .arst_n     (arst_n),
    .bvalid     (1'b0),
    .bready     (1'b0),
    .rvalid     (1'b0),
    .rready     (1'b0),
    .wr         (1'b0),
    .rd         (1'b0),
    .ready      (1'b1),
    .addr       (32'd0),
    .lcd_enable (lcd_enable),
    .lcd_data   (lcd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ********************
  // Output monitors
  // ********************

  always @(negedge clk) begin
    if (lcd_enable) begin
      pulse_len++;
    end else if (enable_prev) begin
      if (pulse_len != int'(LCD_PULSE)) begin
        $display("lcd_enable pulse lasted %0d cycles instead of %0d", pulse_len, LCD_PULSE);
        other_errs++;
      end
      pulse_q.push_back({lcd_rs, lcd_data});
      pulse_len = 0;
      fall_cycle = cycle;
    end
    enable_prev = lcd_enable;
    if (audio_out !== audio_prev) toggle_q.push_back(cycle);
    audio_prev = audio_out;
  end

  task automatic check_data(input data_t got, input data_t exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_resp(input resp_t got, input resp_t exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_lcd(input lcd_byte_t got, input lcd_byte_t exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      lcd_errs++;
    end
  endtask

  task automatic finish_run();
    $display("errors: data %0d, resp %0d, lcd %0d, other %0d",
             data_errs, resp_errs, lcd_errs, other_errs);
    if (data_errs + resp_errs + lcd_errs + other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what, input addr_t addr);
    $display("timeout waiting for %s, address %h", what, addr);
    other_errs++;
    finish_run();
  endtask

  // ********************
  // AXI4-Lite driver
  // ********************

  task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp);
    int n;
    int hold;
    hold    = $urandom_range(2, 0);  // Cycles the master keeps bready low
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(awready && wready) && n < TIMEOUT);
    if (!(awready && wready)) report_timeout("awready and wready", addr);
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!bvalid && n < TIMEOUT);
    if (!bvalid) report_timeout("bvalid", addr);
    bvalid_cycle = cycle;
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      #2 bready = 1'b1;
      @(negedge clk);
    end
    resp = bresp;
    @(posedge clk);
    #2 bready = 1'b0;
  endtask

  task automatic axil_read(input addr_t addr, output data_t data, output resp_t resp);
    int n;
    int hold;
    hold    = $urandom_range(2, 0);  // Cycles the master keeps rready low
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (hold == 0);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < TIMEOUT);
    if (!arready) report_timeout("arready", addr);
    @(posedge clk);
    #2 arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rvalid && n < TIMEOUT);
    if (!rvalid) report_timeout("rvalid", addr);
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      #2 rready = 1'b1;
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #2 rready = 1'b0;
  endtask

  // Upper bits inside the region are random so aliases get exercised
  function automatic addr_t ram_addr(input int idx);
    addr_t a;
    a       = $urandom();
    a[31:30] = 2'b00;
    a[9:2]  = 8'(idx);
    a[1:0]  = 2'b00;
    return a;
  endfunction

  function automatic addr_t unmapped_addr();
    addr_t a;
    a        = $urandom();
    a[31:29] = 3'b010 + 3'($urandom_range(3, 0));  // Patterns 010 to 101
    return a;
  endfunction

  task automatic lcd_write(input lcd_byte_t value, input logic rs);
    resp_t resp;
    axil_write({3'b110, 26'd0, rs, 2'b00}, {24'd0, value}, 4'h1, resp);
    check_resp(resp, RESP_OKAY, "bresp");
    lcd_last = value;
    lcd_exp_q.push_back({rs, value});
  endtask

  task automatic check_lcd_pulses();
    if (pulse_q.size() != lcd_exp_q.size()) begin
      $display("saw %0d lcd_enable pulses, expected %0d", pulse_q.size(), lcd_exp_q.size());
      other_errs++;
    end else begin
      for (int i = 0; i < pulse_q.size(); i++) begin
        check_lcd(pulse_q[i][7:0], lcd_exp_q[i][7:0], "lcd_data");
        check_lcd({7'd0, pulse_q[i][8]}, {7'd0, lcd_exp_q[i][8]}, "lcd_rs");
      end
    end
    pulse_q.delete();
    lcd_exp_q.delete();
  endtask

  task automatic wait_toggles(input int count);
    int n;
    n = 0;
    while (toggle_q.size() < count && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (toggle_q.size() < count) report_timeout("audio_out toggles", 32'hE000_0000);
  endtask

  initial begin
    int          idx;
    data_t       data;
    data_t       rd_val;
    strb_t       strb;
    resp_t       resp;
    void'($urandom(77147));
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (10) @(posedge clk);
    #2 arst_n = 1'b1;
    @(posedge clk);
    #2;

    // ********************
    // RAM
    // ********************

    for (int i = 0; i < 16; i++) begin  // Known contents first
      data = $urandom();
      axil_write(ram_addr(i), data, 4'hF, resp);
      check_resp(resp, RESP_OKAY, "bresp");
      ram_model[i] = data;
    end
    for (int i = 0; i < 200; i++) begin
      idx  = $urandom_range(15, 0);
      data = $urandom();
      strb = strb_t'($urandom());
      axil_write(ram_addr(idx), data, strb, resp);
      check_resp(resp, RESP_OKAY, "bresp");
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) ram_model[idx][8*b +: 8] = data[8*b +: 8];
      end
      idx = $urandom_range(15, 0);
      axil_read(ram_addr(idx), rd_val, resp);
      check_resp(resp, RESP_OKAY, "rresp");
      check_data(rd_val, ram_model[idx], "rdata");
    end

    for (int i = 0; i < 10; i++) begin
      axil_write(unmapped_addr(), $urandom(), 4'hF, resp);
      check_resp(resp, RESP_SLVERR, "bresp");
      axil_read(unmapped_addr(), rd_val, resp);
      check_resp(resp, RESP_SLVERR, "rresp");
      check_data(rd_val, '0, "rdata");
    end

    // ********************
    // LCD
    // ********************

    lcd_write(lcd_byte_t'($urandom()), 1'($urandom()));
    axil_read(32'hC000_0000, rd_val, resp);  // Stalls until the sequence is over
    check_resp(resp, RESP_OKAY, "rresp");
    check_data(rd_val, {23'd0, 1'b0, lcd_last}, "rdata");
    check_lcd_pulses();

    lcd_write(lcd_byte_t'($urandom()), 1'($urandom()));
    lcd_write(lcd_byte_t'($urandom()), 1'($urandom()));
    if (pulse_q.size() < 1) begin
      $display("second LCD write completed before the first enable pulse ended");
      other_errs++;
    end else if (bvalid_cycle - fall_cycle <= int'(LCD_HOLD)) begin
      $display("second LCD write completed before the first hold phase ended");
      other_errs++;
    end
    axil_read(32'hC000_0004, rd_val, resp);
    check_resp(resp, RESP_OKAY, "rresp");
    check_data(rd_val, {23'd0, 1'b0, lcd_last}, "rdata");
    check_lcd_pulses();

    // ********************
    // Audio
    // ********************

    period_model = period_t'($urandom_range(40, 3));
    axil_write(32'hE000_0000, {16'($urandom()), period_model}, 4'hF, resp);
    check_resp(resp, RESP_OKAY, "bresp");
    toggle_q.delete();
    wait_toggles(5);
    for (int i = 1; i < 5; i++) begin
      check_data(data_t'(toggle_q[i] - toggle_q[i-1]), data_t'(period_model),
                 "audio_out interval");
    end
    @(posedge clk);
    #2;
    axil_read(32'hE000_0000, rd_val, resp);
    check_data(rd_val, {16'd0, period_model}, "rdata");

    // A partial write must not touch the period
    axil_write(32'hE000_0000, $urandom(), strb_t'($urandom_range(14, 1)), resp);
    axil_read(32'hE000_0000, rd_val, resp);
    check_data(rd_val, {16'd0, period_model}, "rdata");

    period_model = '0;
    axil_write(32'hE000_0000, 32'd0, 4'hF, resp);
    axil_read(32'hE000_0000, rd_val, resp);
    check_data(rd_val, 32'd0, "rdata");
    repeat (120) begin
      @(negedge clk);
      check_data({31'd0, audio_out}, 32'd0, "audio_out");
    end

    finish_run();
  end

endmodule

// File: verilog.f
logic/soc_map_pkg.sv
logic/periph_pkg.sv
logic/periph_bus_if.sv
logic/axil_bridge.sv
logic/word_ram.sv
logic/lcd_unit.sv
logic/audio_unit.sv
logic/periph_top.sv
sim/periph_sva.sv
sim/periph_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = periph_tb
FILELIST  = verilog.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
